//--- vlog.f
hw/axil_pkg.sv
hw/tape_pkg.sv
hw/tap_fifo.sv
hw/tap_download.sv
hw/tap_player.sv
hw/buffer_arbiter.sv
hw/tape_buffer_top.sv
tb/axil_mem_model.sv
tb/tb_tape_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tape buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_tape_buffer -o sim_tape_buffer

# The log decides the result, so a fatal stop must not end the script early
./obj_dir/sim_tape_buffer > sim.log 2>&1 || true
cat sim.log

if grep -qxF '** PASS **' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tb/tb_tape_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tape_buffer
	import axil_pkg::*;
	import tape_pkg::*;
;

	// Three downloads and three playbacks of up to 40 bytes
	// About 40 cycles per byte at worst
	localparam int TAPE_LEN = 40;
	localparam int TOTAL_BYTES = 6 * TAPE_LEN;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 40 + 2000;

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         ioctl_download;
	logic         ioctl_wr;
	byte_t        ioctl_data;
	logic         ioctl_wait;
	logic         play_toggle;
	logic         unload;
	logic         autoplay_en;
	logic         tape_loaded;
	tap_version_t tap_version;
	byte_t        tap_data;
	logic         tap_valid;
	logic         tap_ready;
	axil_req_t    axil_req;
	axil_rsp_t    axil_rsp;

	byte_t tape_q[$];
	byte_t rx_q[$];

	always #5 clk_sys = ~clk_sys;

	tape_buffer_top dut0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download),
		.ioctl_wr_i       (ioctl_wr),
		.ioctl_data_i     (ioctl_data),
		.ioctl_wait_o     (ioctl_wait),
		.play_toggle_i    (play_toggle),
		.unload_i         (unload),
		.autoplay_en_i    (autoplay_en),
		.tape_loaded_o    (tape_loaded),
		.tap_version_o    (tap_version),
		.tap_data_o       (tap_data),
		.tap_valid_o      (tap_valid),
		.tap_ready_i      (tap_ready),
		.axil_req_o       (axil_req),
		.axil_rsp_i       (axil_rsp)
	);

	axil_mem_model mem0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req_i   (axil_req),
		.rsp_o   (axil_rsp)
	);

	// Collect every byte that moves on the output stream
	always @(posedge clk_sys) begin
		if (!reset && tap_valid && tap_ready) begin
			rx_q.push_back(tap_data);
		end
	end

	//////////////////////////////
	// Error handling
	//////////////////////////////

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t act, input byte_t exp);
		if (act !== exp) begin
			$display("ERR %0t %s: got %02h, expected %02h", $time, name, act, exp);
			abort_run();
		end
	endtask

	task automatic check_version(input string name, input tap_version_t act,
		input tap_version_t exp);
		if (act !== exp) begin
			$display("ERR %0t %s: got %0d, expected %0d", $time, name, act, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("ERR %0t %s: got %b, expected %b", $time, name, act, exp);
			abort_run();
		end
	endtask

	task automatic expect_count(input int n);
		if (rx_q.size() != n) begin
			$display("Stream delivered %0d bytes where %0d were expected, at %0t",
				rx_q.size(), n, $time);
			abort_run();
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic send_byte(input byte_t b);
		while (ioctl_wait) begin
			@(negedge clk_sys);
		end
		ioctl_wr = 1'b1;
		ioctl_data = b;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_flag("ioctl_wait_o", ioctl_wait, 1'b1);
	endtask

	// New random tape kept in tape_q as the expected image
	task automatic download(input int n, input logic autoplay);
		byte_t b;
		tape_q.delete();
		autoplay_en = autoplay;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < n; i++) begin
			b = byte_t'($urandom);
			tape_q.push_back(b);
			send_byte(b);
		end
		while (ioctl_wait) begin
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_toggle();
		play_toggle = 1'b1;
		@(negedge clk_sys);
		play_toggle = 1'b0;
	endtask

	task automatic wait_bytes(input int n, input logic random_ready);
		while (rx_q.size() < n) begin
			@(negedge clk_sys);
			if (random_ready) begin
				tap_ready = 1'($urandom_range(1, 0));
			end
		end
	endtask

	task automatic compare_stream(input int n);
		for (int i = 0; i < n; i++) begin
			check_byte($sformatf("tap_data_o[%0d]", i), rx_q[i], tape_q[i]);
		end
	endtask

	function automatic byte_t mem_byte(input tap_addr_t addr);
		axil_data_t word;
		word = mem0.mem[addr[9:2]];
		return word[8*addr[1:0] +: 8];
	endfunction

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic after_reset();
		check_flag("ioctl_wait_o", ioctl_wait, 1'b0);
		check_flag("tap_valid_o", tap_valid, 1'b0);
		check_flag("tape_loaded_o", tape_loaded, 1'b0);
		check_flag("awvalid", axil_req.awvalid, 1'b0);
		check_flag("wvalid", axil_req.wvalid, 1'b0);
		check_flag("bready", axil_req.bready, 1'b0);
		check_flag("arvalid", axil_req.arvalid, 1'b0);
		check_flag("rready", axil_req.rready, 1'b0);
	endtask

	task automatic download_and_verify();
		download(TAPE_LEN, 1'b0);
		for (int i = 0; i < TAPE_LEN; i++) begin
			check_byte($sformatf("mem[%0d]", i), mem_byte(tap_addr_t'(i)), tape_q[i]);
		end
		check_version("tap_version_o", tap_version, tap_version_t'(tape_q[12][1:0]));
	endtask

	task automatic play_in_order();
		tap_ready = 1'b1;
		rx_q.delete();
		// Prefetch fills the FIFO but nothing leaves before play
		repeat (30) begin
			@(negedge clk_sys);
			check_flag("tap_valid_o", tap_valid, 1'b0);
		end
		check_flag("tape_loaded_o", tape_loaded, 1'b1);
		pulse_toggle();
		wait_bytes(TAPE_LEN, 1'b0);
		compare_stream(TAPE_LEN);
		check_flag("tape_loaded_o", tape_loaded, 1'b0);
		repeat (20) @(negedge clk_sys);
		expect_count(TAPE_LEN);
		check_flag("tap_valid_o", tap_valid, 1'b0);
	endtask

	task automatic pause_under_backpressure();
		int paused_at;
		download(TAPE_LEN, 1'b0);
		rx_q.delete();
		pulse_toggle();
		wait_bytes(15, 1'b1);
		pulse_toggle();
		paused_at = rx_q.size();
		repeat (20) begin
			check_flag("tap_valid_o", tap_valid, 1'b0);
			@(negedge clk_sys);
			tap_ready = 1'($urandom_range(1, 0));
		end
		expect_count(paused_at);
		pulse_toggle();
		wait_bytes(TAPE_LEN, 1'b1);
		tap_ready = 1'b1;
		compare_stream(TAPE_LEN);
		repeat (20) @(negedge clk_sys);
		expect_count(TAPE_LEN);
		check_flag("tape_loaded_o", tape_loaded, 1'b0);
	endtask

	task automatic autoplay_then_unload();
		int kept;
		tap_ready = 1'b1;
		download(TAPE_LEN, 1'b1);
		rx_q.delete();
		wait_bytes(10, 1'b0);
		unload = 1'b1;
		@(negedge clk_sys);
		unload = 1'b0;
		check_flag("tap_valid_o", tap_valid, 1'b0);
		check_flag("tape_loaded_o", tape_loaded, 1'b0);
		kept = rx_q.size();
		compare_stream(kept);
		repeat (40) begin
			@(negedge clk_sys);
			check_flag("tap_valid_o", tap_valid, 1'b0);
			check_flag("tape_loaded_o", tape_loaded, 1'b0);
		end
		expect_count(kept);
		autoplay_en = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h3583));
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_data = '0;
		play_toggle = 1'b0;
		unload = 1'b0;
		autoplay_en = 1'b0;
		tap_ready = 1'b0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;

		after_reset();
		download_and_verify();
		play_in_order();
		pause_under_backpressure();
		autoplay_then_unload();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/axil_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model
	import axil_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire axil_req_t req_i,
	output axil_rsp_t      rsp_o
);

	localparam int MEM_WORDS = 256;

	typedef enum logic [2:0] {
		M_IDLE,
		M_WR_WAIT,
		M_WR_ACK,
		M_WR_RESP,
		M_RD_WAIT,
		M_RD_ACK,
		M_RD_DELAY,
		M_RD_RESP
	} mem_state_e;

	mem_state_e state;
	logic [3:0] delay;
	axil_addr_t rd_addr;
	axil_data_t mem [MEM_WORDS];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= M_IDLE;
			delay <= '0;
			rd_addr <= '0;
			rsp_o <= '0;
			// Known pattern so stale reads stand out
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= {8'hA5 ^ 8'(i), 8'(i), ~8'(i), 8'h3C};
			end
		end else begin
			// Ready strobes last one cycle
			rsp_o.awready <= 1'b0;
			rsp_o.wready <= 1'b0;
			rsp_o.arready <= 1'b0;
			if (delay != 4'd0) begin
				delay <= delay - 4'd1;
			end
			case (state)
				M_IDLE: begin
					if (req_i.awvalid && req_i.wvalid) begin
						delay <= 4'($urandom_range(3, 0));
						state <= M_WR_WAIT;
					end else if (req_i.arvalid) begin
						delay <= 4'($urandom_range(3, 0));
						state <= M_RD_WAIT;
					end
				end
				M_WR_WAIT: begin
					if (delay == 4'd0) begin
						rsp_o.awready <= 1'b1;
						rsp_o.wready <= 1'b1;
						for (int b = 0; b < 4; b++) begin
							if (req_i.wstrb[b]) begin
								mem[req_i.awaddr[9:2]][8*b +: 8] <= req_i.wdata[8*b +: 8];
							end
						end
						state <= M_WR_ACK;
					end
				end
				M_WR_ACK: begin
					rsp_o.bvalid <= 1'b1;
					state <= M_WR_RESP;
				end
				M_WR_RESP: begin
					if (req_i.bready) begin
						rsp_o.bvalid <= 1'b0;
						state <= M_IDLE;
					end
				end
				M_RD_WAIT: begin
					if (delay == 4'd0) begin
						rsp_o.arready <= 1'b1;
						rd_addr <= req_i.araddr;
						state <= M_RD_ACK;
					end
				end
				M_RD_ACK: begin
					delay <= 4'($urandom_range(3, 0));
					state <= M_RD_DELAY;
				end
				M_RD_DELAY: begin
					if (delay == 4'd0) begin
						rsp_o.rvalid <= 1'b1;
						rsp_o.rdata <= mem[rd_addr[9:2]];
						state <= M_RD_RESP;
					end
				end
				M_RD_RESP: begin
					if (req_i.rready) begin
						rsp_o.rvalid <= 1'b0;
						state <= M_IDLE;
					end
				end
				default: begin
					state <= M_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/tape_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module tape_buffer_top
	import axil_pkg::*;
	import tape_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire            ioctl_download_i,
	input  wire            ioctl_wr_i,
	input  wire byte_t     ioctl_data_i,
	output logic           ioctl_wait_o,
	input  wire            play_toggle_i,
	input  wire            unload_i,
	input  wire            autoplay_en_i,
	output logic           tape_loaded_o,
	output tap_version_t   tap_version_o,
	output byte_t          tap_data_o,
	output logic           tap_valid_o,
	input  wire            tap_ready_i,
	output axil_req_t      axil_req_o,
	input  wire axil_rsp_t axil_rsp_i
);

	buf_req_t  dl_req;
	buf_rsp_t  dl_rsp;
	buf_req_t  pl_req;
	buf_rsp_t  pl_rsp;
	tap_addr_t last_addr;
	logic      download_end;
	logic      fifo_push;
	byte_t     fifo_data;
	logic      fifo_flush;
	logic      fifo_pop;
	logic      fifo_empty;
	logic      fifo_full;
	logic      running;

	// Stream is live only while the tape runs
	assign tap_valid_o = ~fifo_empty & running;
	assign fifo_pop = tap_valid_o & tap_ready_i;

	tap_download download0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_data_i     (ioctl_data_i),
		.rsp_i            (dl_rsp),
		.ioctl_wait_o     (ioctl_wait_o),
		.req_o            (dl_req),
		.tap_version_o    (tap_version_o),
		.last_addr_o      (last_addr),
		.download_end_o   (download_end)
	);

	tap_player player0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.download_end_i   (download_end),
		.last_addr_i      (last_addr),
		.autoplay_en_i    (autoplay_en_i),
		.play_toggle_i    (play_toggle_i),
		.unload_i         (unload_i),
		.fifo_full_i      (fifo_full),
		.rsp_i            (pl_rsp),
		.req_o            (pl_req),
		.fifo_push_o      (fifo_push),
		.fifo_data_o      (fifo_data),
		.flush_o          (fifo_flush),
		.running_o        (running),
		.tape_loaded_o    (tape_loaded_o)
	);

	tap_fifo fifo0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.flush_i (fifo_flush),
		.push_i  (fifo_push),
		.data_i  (fifo_data),
		.pop_i   (fifo_pop),
		.data_o  (tap_data_o),
		.empty_o (fifo_empty),
		.full_o  (fifo_full)
	);

	buffer_arbiter arbiter0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_req_i   (dl_req),
		.pl_req_i   (pl_req),
		.axil_rsp_i (axil_rsp_i),
		.dl_rsp_o   (dl_rsp),
		.pl_rsp_o   (pl_rsp),
		.axil_req_o (axil_req_o)
	);

endmodule

`default_nettype wire

//--- hw/buffer_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter
	import axil_pkg::*;
	import tape_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire buf_req_t  dl_req_i,
	input  wire buf_req_t  pl_req_i,
	input  wire axil_rsp_t axil_rsp_i,
	output buf_rsp_t       dl_rsp_o,
	output buf_rsp_t       pl_rsp_o,
	output axil_req_t      axil_req_o
);

	typedef enum logic [2:0] {
		ARB_IDLE,
		ARB_WR_ADDR_DATA,
		ARB_WR_RESP,
		ARB_RD_ADDR,
		ARB_RD_DATA
	} arb_state_e;

	arb_state_e state;
	logic       gnt_dl;
	buf_req_t   sel_req;
	axil_req_t  req_q;
	axil_data_t rd_word;
	byte_t      rd_byte;
	logic       aw_done;
	logic       w_done;
	logic       xfer_done;

	// Download peer wins when both ask
	assign sel_req = dl_req_i.valid ? dl_req_i : pl_req_i;

	assign aw_done = ~req_q.awvalid | axil_rsp_i.awready;
	assign w_done = ~req_q.wvalid | axil_rsp_i.wready;
	assign xfer_done = ((state == ARB_WR_RESP) & axil_rsp_i.bvalid)
		| ((state == ARB_RD_DATA) & axil_rsp_i.rvalid);

	// Read byte comes from the lane of the two low address bits
	assign rd_word = axil_rsp_i.rdata >> {req_q.araddr[1:0], 3'b000};
	assign rd_byte = rd_word[7:0];

	assign axil_req_o = req_q;

	always_comb begin
		dl_rsp_o.done = xfer_done & gnt_dl;
		dl_rsp_o.data = rd_byte;
		pl_rsp_o.done = xfer_done & ~gnt_dl;
		pl_rsp_o.data = rd_byte;
	end

	//////////////////////////////
	// AXI4-Lite phases
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ARB_IDLE;
			gnt_dl <= 1'b0;
			req_q <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (sel_req.valid) begin
						gnt_dl <= dl_req_i.valid;
						if (sel_req.write) begin
							// AW and W go out together
							req_q.awaddr <= sel_req.addr;
							req_q.awvalid <= 1'b1;
							req_q.wdata <= axil_data_t'(sel_req.data) << {sel_req.addr[1:0], 3'b000};
							req_q.wstrb <= axil_strb_t'(1) << sel_req.addr[1:0];
							req_q.wvalid <= 1'b1;
							state <= ARB_WR_ADDR_DATA;
						end else begin
							req_q.araddr <= sel_req.addr;
							req_q.arvalid <= 1'b1;
							state <= ARB_RD_ADDR;
						end
					end
				end
				ARB_WR_ADDR_DATA: begin
					if (axil_rsp_i.awready) begin
						req_q.awvalid <= 1'b0;
					end
					if (axil_rsp_i.wready) begin
						req_q.wvalid <= 1'b0;
					end
					if (aw_done && w_done) begin
						req_q.bready <= 1'b1;
						state <= ARB_WR_RESP;
					end
				end
				ARB_WR_RESP: begin
					if (axil_rsp_i.bvalid) begin
						req_q.bready <= 1'b0;
						state <= ARB_IDLE;
					end
				end
				ARB_RD_ADDR: begin
					if (axil_rsp_i.arready) begin
						req_q.arvalid <= 1'b0;
						req_q.rready <= 1'b1;
						state <= ARB_RD_DATA;
					end
				end
				ARB_RD_DATA: begin
					if (axil_rsp_i.rvalid) begin
						req_q.rready <= 1'b0;
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/tap_player.sv
`timescale 1ns/1ps
`default_nettype none

module tap_player
	import tape_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire           ioctl_download_i,
	input  wire           download_end_i,
	input  wire tap_addr_t last_addr_i,
	input  wire           autoplay_en_i,
	input  wire           play_toggle_i,
	input  wire           unload_i,
	input  wire           fifo_full_i,
	input  wire buf_rsp_t rsp_i,
	output buf_req_t      req_o,
	output logic          fifo_push_o,
	output byte_t         fifo_data_o,
	output logic          flush_o,
	output logic          running_o,
	output logic          tape_loaded_o
);

	player_state_e state;
	tap_addr_t     play_addr;
	tap_addr_t     last_addr;
	logic          running;
	logic          discard;
	logic          clear;
	logic          drop;
	buf_req_t      req_q;

	assign clear = ioctl_download_i | unload_i;

	// A read started before a clear completes but its byte is thrown away
	assign drop = discard | clear;

	assign tape_loaded_o = play_addr < last_addr;
	assign flush_o = clear;
	assign running_o = running;
	assign req_o = req_q;
	assign fifo_push_o = (state == PL_READING) & rsp_i.done & ~drop;
	assign fifo_data_o = rsp_i.data;

	//////////////////////////////
	// Tape controls
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_addr <= '0;
			running <= 1'b0;
		end else if (unload_i) begin
			last_addr <= '0;
			running <= 1'b0;
		end else if (ioctl_download_i) begin
			running <= 1'b0;
		end else if (download_end_i) begin
			last_addr <= last_addr_i;
			running <= autoplay_en_i;
		end else if (play_toggle_i) begin
			running <= ~running;
		end
	end

	//////////////////////////////
	// Buffer fetch
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= PL_IDLE;
			play_addr <= '0;
			discard <= 1'b0;
			req_q <= '0;
		end else begin
			case (state)
				PL_IDLE: begin
					// Prefetch even while paused
					if (!clear && tape_loaded_o && !fifo_full_i) begin
						req_q.valid <= 1'b1;
						req_q.write <= 1'b0;
						req_q.addr <= play_addr;
						state <= PL_READING;
					end
				end
				PL_READING: begin
					if (rsp_i.done) begin
						req_q.valid <= 1'b0;
						discard <= 1'b0;
						state <= PL_IDLE;
						if (!drop) begin
							play_addr <= play_addr + 1'b1;
						end
					end else if (clear) begin
						discard <= 1'b1;
					end
				end
				default: begin
					state <= PL_IDLE;
				end
			endcase

			if (clear) begin
				play_addr <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/tap_download.sv
`timescale 1ns/1ps
`default_nettype none

module tap_download
	import tape_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire           ioctl_download_i,
	input  wire           ioctl_wr_i,
	input  wire byte_t    ioctl_data_i,
	input  wire buf_rsp_t rsp_i,
	output logic          ioctl_wait_o,
	output buf_req_t      req_o,
	output tap_version_t  tap_version_o,
	output tap_addr_t     last_addr_o,
	output logic          download_end_o
);

	tap_addr_t wr_addr;
	logic      dl_prev;
	logic      host_wr;
	buf_req_t  req_q;

	assign host_wr = ioctl_download_i & ioctl_wr_i;
	assign req_o = req_q;

	// Byte count is still valid in the cycle after download drops
	assign download_end_o = dl_prev & ~ioctl_download_i;
	assign last_addr_o = wr_addr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev <= 1'b0;
			wr_addr <= '0;
			ioctl_wait_o <= 1'b0;
			req_q <= '0;
			tap_version_o <= '0;
		end else begin
			dl_prev <= ioctl_download_i;

			if (host_wr) begin
				// One buffer write per host byte
				req_q.valid <= 1'b1;
				req_q.write <= 1'b1;
				req_q.addr <= wr_addr;
				req_q.data <= ioctl_data_i;
				ioctl_wait_o <= 1'b1;
				wr_addr <= wr_addr + 1'b1;
				if (wr_addr == TAP_VERSION_OFFSET) begin
					tap_version_o <= ioctl_data_i[1:0];
				end
			end else if (rsp_i.done) begin
				req_q.valid <= 1'b0;
				ioctl_wait_o <= 1'b0;
			end

			// Next download counts from zero again
			if (download_end_o) begin
				wr_addr <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/tap_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tap_fifo
	import tape_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        flush_i,
	input  wire        push_i,
	input  wire byte_t data_i,
	input  wire        pop_i,
	output byte_t      data_o,
	output logic       empty_o,
	output logic       full_o
);

	byte_t                     mem [TAP_FIFO_DEPTH];
	logic [TAP_FIFO_PTR_W-1:0] wr_ptr;
	logic [TAP_FIFO_PTR_W-1:0] rd_ptr;
	logic [TAP_FIFO_PTR_W:0]   count;
	logic                      do_push;
	logic                      do_pop;

	assign empty_o = (count == '0);
	assign full_o = (count == (TAP_FIFO_PTR_W+1)'(TAP_FIFO_DEPTH));
	assign do_push = push_i & ~full_o;
	assign do_pop = pop_i & ~empty_o;
	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk_sys) begin
		if (reset || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/tape_pkg.sv
`default_nettype none

// Tape image types, constants and the buffer peer port
package tape_pkg;

	import axil_pkg::*;

	typedef logic [AXIL_ADDR_W-1:0] tap_addr_t;
	typedef logic [7:0]             byte_t;
	typedef logic [1:0]             tap_version_t;

	// TAP header byte holding the format version
	localparam tap_addr_t TAP_VERSION_OFFSET = 25'h00000C;

	// Playback FIFO size, must stay a power of two
	localparam int TAP_FIFO_DEPTH = 16;
	localparam int TAP_FIFO_PTR_W = $clog2(TAP_FIFO_DEPTH);

	// Request from a peer, held until done
	typedef struct packed {
		logic      valid;
		logic      write;
		tap_addr_t addr;
		byte_t     data;
	} buf_req_t;

	// Answer from the arbiter, done lasts one cycle
	typedef struct packed {
		logic  done;
		byte_t data;
	} buf_rsp_t;

	typedef enum logic {
		PL_IDLE,
		PL_READING
	} player_state_e;

endpackage

`default_nettype wire

//--- hw/axil_pkg.sv
`default_nettype none

// AXI4-Lite bus widths and the two halves of the bus
package axil_pkg;

	localparam int AXIL_ADDR_W = 25;
	localparam int AXIL_DATA_W = 32;

	typedef logic [AXIL_ADDR_W-1:0]   axil_addr_t;
	typedef logic [AXIL_DATA_W-1:0]   axil_data_t;
	typedef logic [AXIL_DATA_W/8-1:0] axil_strb_t;

	// Driven by the master
	typedef struct packed {
		axil_addr_t awaddr;
		logic       awvalid;
		axil_data_t wdata;
		axil_strb_t wstrb;
		logic       wvalid;
		logic       bready;
		axil_addr_t araddr;
		logic       arvalid;
		logic       rready;
	} axil_req_t;

	// Driven by the slave
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire
